/* all.f */
hw/touch_pkg.sv
hw/touch_sclk_gen.sv
hw/touch_shift_out.sv
hw/touch_shift_in.sv
hw/touch_frame_seq.sv
hw/touch_coord_store.sv
hw/touchpad_controller.sv
verification/touch_adc_model.sv
verification/tb_touchpad_controller.sv

/* hw/touch_coord_store.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_coord_store (
	input logic cclk,
	input logic counter_rst,
	input logic sample_take,
	input touch_pkg::coord_t sample,
	input touch_pkg::dim_t dim,
	output touch_pkg::coord_t x,
	output touch_pkg::coord_t y,
	output touch_pkg::coord_t z,
	output logic coord_valid,
	output touch_pkg::dim_t coord_dim
);

	touch_pkg::coord_t calibrated;

	// Subtract the offset, floor at zero, clip at the top of the range
	function automatic touch_pkg::coord_t calibrate(input touch_pkg::coord_t raw,
		input touch_pkg::coord_t adj_min, input touch_pkg::coord_t post_max);
		touch_pkg::coord_t diff;
		diff = raw - adj_min;
		if (raw < adj_min) begin
			return '0;
		end
		return (diff > post_max) ? post_max : diff;
	endfunction

	always_comb begin
		case (dim)
			touch_pkg::DIM_X: calibrated = calibrate(sample, touch_pkg::X_ADJ_MIN,
				touch_pkg::X_POST_ADJ_MAX);
			touch_pkg::DIM_Y: calibrated = calibrate(sample, touch_pkg::Y_ADJ_MIN,
				touch_pkg::Y_POST_ADJ_MAX);
			// Pressure passes through raw
			default: calibrated = sample;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			x <= touch_pkg::COORD_RESET;
			y <= touch_pkg::COORD_RESET;
			z <= touch_pkg::COORD_RESET;
			coord_valid <= 1'b0;
			coord_dim <= touch_pkg::DIM_X;
		end else begin
			coord_valid <= sample_take;
			if (sample_take) begin
				coord_dim <= dim;
				case (dim)
					touch_pkg::DIM_X: x <= calibrated;
					touch_pkg::DIM_Y: y <= calibrated;
					touch_pkg::DIM_Z: z <= calibrated;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* hw/touch_frame_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_frame_seq #(
	parameter int REPETITIONS = 16
) (
	input logic cclk,
	input logic counter_rst,
	input logic sclk_rise,
	output logic touch_csb,
	output logic shift_load,
	output logic sample_take,
	output logic [4:0] bit_count,
	output touch_pkg::cmd_t cmd,
	output touch_pkg::dim_t dim
);

	localparam int REP_W = $clog2(REPETITIONS + 1);
	localparam logic [REP_W-1:0] REP_LAST = REP_W'(REPETITIONS - 1);

	logic [REP_W-1:0] rep_count;
	logic primed;
	logic frame_done;
	logic last_rep;

	assign frame_done = sclk_rise && (bit_count == touch_pkg::FRAME_END);
	assign last_rep = (rep_count == REP_LAST);
	assign sample_take = frame_done && last_rep;

	// Start bit, A-field, then fixed mode and power-down bits
	assign cmd = {1'b1, dim, 5'b10011};

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			touch_csb <= 1'b1;
			primed <= 1'b0;
			// First command loads right after reset
			shift_load <= 1'b1;
		end else begin
			touch_csb <= 1'b0;
			shift_load <= frame_done;
			if (sclk_rise) begin
				primed <= 1'b1;
			end
		end
	end

	// First rise after reset only opens count 0
	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			bit_count <= '0;
		end else if (sclk_rise && primed) begin
			bit_count <= frame_done ? 5'd0 : bit_count + 5'd1;
		end
	end

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			rep_count <= '0;
		end else if (frame_done) begin
			rep_count <= last_rep ? '0 : rep_count + 1'b1;
		end
	end

	// Rotate X, Y, Z after the last repetition
	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			dim <= touch_pkg::DIM_X;
		end else if (sample_take) begin
			case (dim)
				touch_pkg::DIM_X: dim <= touch_pkg::DIM_Y;
				touch_pkg::DIM_Y: dim <= touch_pkg::DIM_Z;
				default: dim <= touch_pkg::DIM_X;
			endcase
		end
	end

	assert property (@(posedge cclk) disable iff (counter_rst)
		dim != touch_pkg::DIM_INVALID);

endmodule

`default_nettype wire

/* hw/touch_pkg.sv */
`default_nettype none

package touch_pkg;

	typedef logic [11:0] coord_t;
	typedef logic [1:0] dim_t;
	typedef logic [7:0] cmd_t;

	// Dimension codes, sent as the A-field of the command
	localparam dim_t DIM_Y = 2'd0;
	localparam dim_t DIM_X = 2'd1;
	localparam dim_t DIM_Z = 2'd2;
	localparam dim_t DIM_INVALID = 2'd3;

	// Positions within a 25-count frame
	localparam logic [4:0] CALL_END = 5'd8;
	localparam logic [4:0] RESPONSE_START = 5'd9;
	// Exclusive bound of the sample window
	localparam logic [4:0] RESPONSE_END = 5'd21;
	localparam logic [4:0] FRAME_END = 5'd24;

	// Calibration limits for X and Y
	localparam coord_t X_ADJ_MIN = 12'h096;
	localparam coord_t X_POST_ADJ_MAX = 12'hF6E;
	localparam coord_t Y_ADJ_MIN = 12'h12C;
	localparam coord_t Y_POST_ADJ_MAX = 12'hED8;

	localparam coord_t COORD_RESET = 12'd1000;

endpackage

`default_nettype wire

/* hw/touch_sclk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_sclk_gen #(
	parameter int CLK_DIV = 25
) (
	input logic cclk,
	input logic counter_rst,
	output logic touch_clk,
	output logic sclk_rise,
	output logic sclk_fall
);

	localparam int DIV_W = $clog2(CLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

	logic [DIV_W-1:0] div_count;
	logic div_done;

	assign div_done = (div_count == DIV_LAST);

	// Strobes mark the cycle whose closing edge toggles touch_clk
	assign sclk_rise = div_done && !touch_clk;
	assign sclk_fall = div_done && touch_clk;

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			div_count <= '0;
			touch_clk <= 1'b0;
		end else if (div_done) begin
			div_count <= '0;
			touch_clk <= !touch_clk;
		end else begin
			div_count <= div_count + 1'b1;
		end
	end

	// A rise strobe is always followed by touch_clk high, never by a second strobe
	assert property (@(posedge cclk) disable iff (counter_rst)
		sclk_rise |=> (touch_clk && !sclk_rise && !sclk_fall));

endmodule

`default_nettype wire

/* hw/touch_shift_in.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_shift_in (
	input logic cclk,
	input logic counter_rst,
	input logic sclk_rise,
	input logic data_in,
	input logic [4:0] bit_count,
	output touch_pkg::coord_t sample
);

	logic in_window;

	assign in_window = (bit_count >= touch_pkg::RESPONSE_START) &&
		(bit_count < touch_pkg::RESPONSE_END);

	// MSB arrives first, so shift left
	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			sample <= '0;
		end else if (sclk_rise && in_window) begin
			sample <= {sample[10:0], data_in};
		end
	end

	// Sample must stay put from the end of the window to the frame end
	assert property (@(posedge cclk) disable iff (counter_rst)
		!in_window |=> $stable(sample));

endmodule

`default_nettype wire

/* hw/touch_shift_out.sv */
`timescale 1ns/1ps
`default_nettype none

module touch_shift_out (
	input logic cclk,
	input logic counter_rst,
	input logic shift_load,
	input logic sclk_fall,
	input touch_pkg::cmd_t cmd,
	input logic [4:0] bit_count,
	output logic data_out
);

	touch_pkg::cmd_t shift_reg;
	touch_pkg::cmd_t next_word;
	logic in_call;

	assign in_call = (bit_count < touch_pkg::CALL_END);

	// A load in the same cycle as a falling edge sends the new command
	assign next_word = shift_load ? cmd : shift_reg;

	// Bit k goes out on the fall inside count k, the converter takes it on the next rise
	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			data_out <= 1'b0;
		end else if (sclk_fall) begin
			data_out <= in_call ? next_word[7] : 1'b0;
		end
	end

	always_ff @(posedge cclk) begin
		if (sclk_fall && in_call) begin
			shift_reg <= {next_word[6:0], 1'b0};
		end else if (shift_load) begin
			shift_reg <= cmd;
		end
	end

endmodule

`default_nettype wire

/* hw/touchpad_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module touchpad_controller #(
	parameter int CLK_DIV = 25,
	parameter int REPETITIONS = 16
) (
	input logic cclk,
	input logic counter_rst,
	// Busy is not needed, the frame timing is fixed
	input logic touch_busy,
	input logic data_in,
	output logic touch_clk,
	output logic data_out,
	output logic touch_csb,
	output logic coord_valid,
	output touch_pkg::coord_t x,
	output touch_pkg::coord_t y,
	output touch_pkg::coord_t z,
	output touch_pkg::dim_t coord_dim
);

	logic sclk_rise;
	logic sclk_fall;
	logic shift_load;
	logic sample_take;
	logic [4:0] bit_count;
	touch_pkg::cmd_t cmd;
	touch_pkg::dim_t dim;
	touch_pkg::coord_t sample;

	touch_sclk_gen #(
		.CLK_DIV(CLK_DIV)
	) u_sclk_gen (
		.cclk(cclk),
		.counter_rst(counter_rst),
		.touch_clk(touch_clk),
		.sclk_rise(sclk_rise),
		.sclk_fall(sclk_fall)
	);

	touch_frame_seq #(
		.REPETITIONS(REPETITIONS)
	) u_frame_seq (
		.cclk(cclk),
		.counter_rst(counter_rst),
		.sclk_rise(sclk_rise),
		.touch_csb(touch_csb),
		.shift_load(shift_load),
		.sample_take(sample_take),
		.bit_count(bit_count),
		.cmd(cmd),
		.dim(dim)
	);

	touch_shift_out u_shift_out (
		.cclk(cclk),
		.counter_rst(counter_rst),
		.shift_load(shift_load),
		.sclk_fall(sclk_fall),
		.cmd(cmd),
		.bit_count(bit_count),
		.data_out(data_out)
	);

	touch_shift_in u_shift_in (
		.cclk(cclk),
		.counter_rst(counter_rst),
		.sclk_rise(sclk_rise),
		.data_in(data_in),
		.bit_count(bit_count),
		.sample(sample)
	);

	touch_coord_store u_coord_store (
		.cclk(cclk),
		.counter_rst(counter_rst),
		.sample_take(sample_take),
		.sample(sample),
		.dim(dim),
		.x(x),
		.y(y),
		.z(z),
		.coord_valid(coord_valid),
		.coord_dim(coord_dim)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_touchpad_controller -f all.f \
	&& ./obj_dir/Vtb_touchpad_controller > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* verification/tb_touchpad_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_touchpad_controller;

	localparam int CLK_DIV = 4;
	localparam int REPETITIONS = 3;
	localparam int N_GROUPS = 9;
	localparam int FRAME_CYCLES = 25 * 2 * CLK_DIV;
	localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES;

	logic cclk;
	logic counter_rst;
	logic touch_busy;
	logic data_in;
	logic touch_clk;
	logic data_out;
	logic touch_csb;
	logic coord_valid;
	touch_pkg::coord_t x;
	touch_pkg::coord_t y;
	touch_pkg::coord_t z;
	touch_pkg::dim_t coord_dim;

	int model_frames;
	touch_pkg::cmd_t model_cmd;
	touch_pkg::coord_t model_value;

	// Last sample sent per dimension, and the register contents expected now
	touch_pkg::coord_t sent_value [4];
	touch_pkg::coord_t held [3];
	int seen_frames = 0;
	int reset_fails = 0;
	int clock_fails = 0;
	int cmd_fails = 0;
	int order_fails = 0;
	int cal_fails = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	bit timed_out = 1'b0;

	touchpad_controller #(
		.CLK_DIV(CLK_DIV),
		.REPETITIONS(REPETITIONS)
	) DUT (
		.cclk(cclk),
		.counter_rst(counter_rst),
		.touch_busy(touch_busy),
		.data_in(data_in),
		.touch_clk(touch_clk),
		.data_out(data_out),
		.touch_csb(touch_csb),
		.coord_valid(coord_valid),
		.x(x),
		.y(y),
		.z(z),
		.coord_dim(coord_dim)
	);

	touch_adc_model #(
		.REPETITIONS(REPETITIONS)
	) u_adc (
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.data_out(data_out),
		.data_in(data_in),
		.frame_count(model_frames),
		.last_cmd(model_cmd),
		.last_value(model_value)
	);

	always #50 cclk = !cclk;

	// X, Y, Z in turn, one group of frames each
	function automatic touch_pkg::dim_t dim_order(input int group);
		case (group % 3)
			0: return touch_pkg::DIM_X;
			1: return touch_pkg::DIM_Y;
			default: return touch_pkg::DIM_Z;
		endcase
	endfunction

	function automatic touch_pkg::coord_t expected_coord(input touch_pkg::dim_t dim,
		input touch_pkg::coord_t raw);
		int offset;
		int top;
		int level;
		if (dim == touch_pkg::DIM_Z) begin
			return raw;
		end
		offset = (dim == touch_pkg::DIM_X) ? int'(touch_pkg::X_ADJ_MIN) :
			int'(touch_pkg::Y_ADJ_MIN);
		top = (dim == touch_pkg::DIM_X) ? int'(touch_pkg::X_POST_ADJ_MAX) :
			int'(touch_pkg::Y_POST_ADJ_MAX);
		level = int'(raw) - offset;
		if (level < 0) begin
			level = 0;
		end else if (level > top) begin
			level = top;
		end
		return touch_pkg::coord_t'(level);
	endfunction

	task automatic next_cycle();
		@(posedge cclk);
		#1;
	endtask

	task automatic check_coord(input string name, input touch_pkg::coord_t got,
		input touch_pkg::coord_t want, inout int fails);
		if (got !== want) begin
			$display("Fail at %0t: %s is 0x%03h, expected 0x%03h", $time, name, got, want);
			fails++;
		end
	endtask

	task automatic check_dim(input string name, input touch_pkg::dim_t got,
		input touch_pkg::dim_t want, inout int fails);
		if (got !== want) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, want);
			fails++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want,
		inout int fails);
		if (got !== want) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, want);
			fails++;
		end
	endtask

	task automatic check_command(input int index, input touch_pkg::cmd_t word);
		touch_pkg::dim_t want;
		want = dim_order(index / REPETITIONS);
		if (word[7] !== 1'b1) begin
			$display("Command of frame %0d (0x%02h) has no start bit", index, word);
			cmd_fails++;
		end
		if (word[4:0] !== 5'b10011) begin
			$display("Command of frame %0d (0x%02h) has wrong mode bits", index, word);
			cmd_fails++;
		end
		if (word[6:5] !== want) begin
			$display("Command of frame %0d asks for dimension %0d instead of %0d",
				index, word[6:5], want);
			cmd_fails++;
		end
	endtask

	// Only the register of the finished dimension may differ from before
	task automatic check_registers(input touch_pkg::dim_t changed);
		int miss [3];
		for (int i = 0; i < 3; i++) begin
			miss[i] = 0;
		end
		check_coord("x", x, held[touch_pkg::DIM_X], miss[touch_pkg::DIM_X]);
		check_coord("y", y, held[touch_pkg::DIM_Y], miss[touch_pkg::DIM_Y]);
		check_coord("z", z, held[touch_pkg::DIM_Z], miss[touch_pkg::DIM_Z]);
		for (int i = 0; i < 3; i++) begin
			if (i == int'(changed)) begin
				cal_fails += miss[i];
			end else begin
				order_fails += miss[i];
			end
		end
	endtask

	task automatic wait_coord_valid(output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
			next_cycle();
			seen = (coord_valid === 1'b1);
		end
	endtask

	task automatic wait_touch_rise(output bit seen, output int cycles);
		logic prev;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			prev = touch_clk;
			next_cycle();
			cycles++;
			seen = (prev === 1'b0) && (touch_clk === 1'b1);
		end
	endtask

	task automatic report_result(input string name, input int fails);
		if (fails == 0) begin
			$display("%s: passed", name);
			tests_passed++;
		end else begin
			$display("%s: %0d checks failed", name, fails);
			tests_failed++;
		end
	endtask

	// Each command the converter decodes is checked once
	always @(posedge cclk) begin
		if (model_frames != seen_frames) begin
			check_command(seen_frames, model_cmd);
			sent_value[model_cmd[6:5]] = model_value;
			seen_frames = seen_frames + 1;
		end
	end

	initial begin
		bit ok;
		int period;
		touch_pkg::dim_t d;
		cclk = 1'b0;
		counter_rst = 1'b1;
		touch_busy = 1'b0;
		for (int i = 0; i < 4; i++) begin
			sent_value[i] = '0;
		end
		for (int i = 0; i < 3; i++) begin
			held[i] = touch_pkg::COORD_RESET;
		end

		repeat (4) @(posedge cclk);
		#1;
		check_bit("touch_csb", touch_csb, 1'b1, reset_fails);
		check_bit("touch_clk", touch_clk, 1'b0, reset_fails);
		check_coord("x", x, touch_pkg::COORD_RESET, reset_fails);
		check_coord("y", y, touch_pkg::COORD_RESET, reset_fails);
		check_coord("z", z, touch_pkg::COORD_RESET, reset_fails);
		repeat (4) @(posedge cclk);
		#1;
		counter_rst = 1'b0;
		next_cycle();
		check_bit("touch_csb", touch_csb, 1'b0, reset_fails);
		report_result("reset", reset_fails);

		// Two rising edges of touch_clk, counting cclk cycles between them
		wait_touch_rise(ok, period);
		if (ok) begin
			wait_touch_rise(ok, period);
		end
		if (!ok) begin
			$display("Timed out waiting for a rising edge of touch_clk");
			timed_out = 1'b1;
			clock_fails++;
		end else if (period != 2 * CLK_DIV) begin
			$display("Fail at %0t: touch_clk period is %0d, expected %0d",
				$time, period, 2 * CLK_DIV);
			clock_fails++;
		end
		report_result("touch_clk period", clock_fails);

		for (int g = 0; g < N_GROUPS && !timed_out; g++) begin
			wait_coord_valid(ok);
			if (!ok) begin
				$display("Timed out waiting for coord_valid of group %0d", g);
				timed_out = 1'b1;
				order_fails++;
			end else begin
				d = dim_order(g);
				check_dim("coord_dim", coord_dim, d, order_fails);
				held[d] = expected_coord(d, sent_value[d]);
				check_registers(d);
			end
		end

		if (!timed_out && seen_frames < N_GROUPS * REPETITIONS) begin
			$display("Only %0d commands were decoded, expected at least %0d",
				seen_frames, N_GROUPS * REPETITIONS);
			cmd_fails++;
		end
		report_result("commands", cmd_fails);
		report_result("order and selection", order_fails);
		report_result("calibration", cal_fails);

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (timed_out || tests_failed != 0) begin
			$display("Test failed");
		end else begin
			$display("Test completed successfully");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/touch_adc_model.sv */
`timescale 1ns/1ps
`default_nettype none

// Behavioral converter of the ADS7843 kind, seen from the controller pins
module touch_adc_model #(
	parameter int REPETITIONS = 16
) (
	input logic touch_clk,
	input logic touch_csb,
	input logic data_out,
	output logic data_in,
	output int frame_count,
	output touch_pkg::cmd_t last_cmd,
	output touch_pkg::coord_t last_value
);

	logic in_frame;
	int pos;
	touch_pkg::cmd_t cmd_bits;
	touch_pkg::coord_t value;

	// Earlier frames stay mid-range and kept frames lie outside it
	function automatic touch_pkg::coord_t pick_sample(input int index,
		input touch_pkg::dim_t dim);
		int round;
		int offset;
		logic kept;
		logic xy;
		touch_pkg::coord_t v;
		round = (index / REPETITIONS) / 3;
		kept = ((index % REPETITIONS) == REPETITIONS - 1);
		xy = (dim == touch_pkg::DIM_X) || (dim == touch_pkg::DIM_Y);
		offset = (dim == touch_pkg::DIM_X) ? int'(touch_pkg::X_ADJ_MIN) :
			int'(touch_pkg::Y_ADJ_MIN);
		if (!kept) begin
			v = touch_pkg::coord_t'(32'h200 + ($urandom % 32'hC00));
		end else if (xy && round == 1) begin
			// Below the offset
			v = touch_pkg::coord_t'($urandom % offset);
		end else if (xy && round == 2) begin
			// Top of the converter range
			v = 12'hFFF;
		end else begin
			// Above the mid range of the earlier frames
			v = touch_pkg::coord_t'(32'hE00 + ($urandom % 32'h200));
		end
		return v;
	endfunction

	// Command bits are taken on touch_clk rising edges
	initial begin
		in_frame = 1'b0;
		pos = 0;
		frame_count = 0;
		cmd_bits = '0;
		value = '0;
		last_cmd = '0;
		last_value = '0;
		void'($urandom(51));
		forever begin
			@(posedge touch_clk);
			#1;
			if (touch_csb) begin
				in_frame = 1'b0;
			end else if (!in_frame) begin
				// Idle until the first start bit shows up
				if (data_out) begin
					in_frame = 1'b1;
					pos = 0;
					cmd_bits = 8'h01;
				end
			end else begin
				// Later frames follow every 25 clocks, start bit included
				pos = (pos == 24) ? 0 : pos + 1;
				if (pos <= 7) begin
					cmd_bits = {cmd_bits[6:0], data_out};
				end
				if (pos == 7) begin
					value = pick_sample(frame_count, cmd_bits[6:5]);
					last_cmd = cmd_bits;
					last_value = value;
					frame_count = frame_count + 1;
				end
			end
		end
	end

	// MSB goes out on the fall inside count 9, LSB inside count 20
	initial begin
		data_in = 1'b0;
		forever begin
			@(negedge touch_clk);
			#1;
			if (in_frame && pos >= 8 && pos <= 19) begin
				data_in = value[19 - pos];
			end else begin
				data_in = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire
